/* logic/ex_config.svh */
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

`default_nettype none

// datapath width of the integer execute stage
`define EX_XLEN 64

// one multiplier operand bit is consumed per step
`define EX_MUL_STEPS 64

`default_nettype wire

`endif

/* logic/ex_pkg.sv */
`include "ex_config.svh"
`default_nettype none

package ex_pkg;

    // integer ALU operations
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLT   = 4'd2,
        ALU_SLTU  = 4'd3,
        ALU_SLL   = 4'd4,
        ALU_SRL   = 4'd5,
        ALU_SRA   = 4'd6,
        ALU_XOR   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10
    } alu_op_e;

    // multiplier result kinds, low half or high half with operand signedness
    typedef enum logic [1:0] {
        MUL_LO  = 2'd0,
        MUL_HSS = 2'd1,
        MUL_HSU = 2'd2,
        MUL_HUU = 2'd3
    } mul_op_e;

    typedef struct packed {
        logic                is_mul;
        alu_op_e             alu_op;
        mul_op_e             mul_op;
        logic                word;
        logic [`EX_XLEN-1:0] src_a;
        logic [`EX_XLEN-1:0] src_b;
    } ex_req_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0] result;
        logic                zero;
        logic                less;
    } ex_resp_t;

endpackage

`default_nettype wire

/* logic/ex_result_stage.sv */
`include "ex_config.svh"
`timescale 1ns/10ps
`default_nettype none

module ex_result_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                alu_valid_i,
    input  ex_pkg::ex_resp_t    alu_resp_i,
    input  logic                alu_word_i,
    input  logic                mul_done_i,
    input  logic [`EX_XLEN-1:0] mul_product_i,
    input  logic                mul_word_i,
    input  logic                mul_busy_i,
    output logic                resp_valid_o,
    output ex_pkg::ex_resp_t    resp_o,
    output logic                busy_o
);

    localparam int HALF = `EX_XLEN / 2;

    ex_pkg::ex_resp_t sel_resp;
    ex_pkg::ex_resp_t next_resp;
    logic             sel_word;

    // multiply results carry no flags
    always_comb begin
        if (mul_done_i) begin
            sel_resp.result = mul_product_i;
            sel_resp.zero   = 1'b0;
            sel_resp.less   = 1'b0;
            sel_word        = mul_word_i;
        end else begin
            sel_resp = alu_resp_i;
            sel_word = alu_word_i;
        end
    end

    always_comb begin
        next_resp = sel_resp;
        if (sel_word) begin
            next_resp.result = {{HALF{sel_resp.result[HALF-1]}}, sel_resp.result[HALF-1:0]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid_o <= 1'b0;
            resp_o       <= '0;
        end else begin
            resp_valid_o <= alu_valid_i | mul_done_i;
            if (alu_valid_i || mul_done_i) begin
                resp_o <= next_resp;
            end
        end
    end

    // the done cycle still counts as busy until the response is out
    assign busy_o = mul_busy_i | mul_done_i;

endmodule

`default_nettype wire

/* logic/ex_unit_top.sv */
`include "ex_config.svh"
`timescale 1ns/10ps
`default_nettype none

module ex_unit_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req_valid_i,
    input  ex_pkg::ex_req_t  req_i,
    input  logic             flush_i,
    output logic             resp_valid_o,
    output ex_pkg::ex_resp_t resp_o,
    output logic             busy_o
);

    ex_pkg::ex_resp_t    alu_resp;
    logic                alu_valid;
    logic                mul_start;
    logic                mul_done;
    logic                mul_busy;
    logic                mul_word_q;
    logic [`EX_XLEN-1:0] mul_product;

    // requests during busy are dropped
    assign alu_valid = req_valid_i && !req_i.is_mul && !busy_o;
    assign mul_start = req_valid_i && req_i.is_mul && !busy_o;

    // word flag must survive the whole multiply
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_word_q <= 1'b0;
        end else if (mul_start) begin
            mul_word_q <= req_i.word;
        end
    end

    int_alu u_alu (
        .req_i  (req_i),
        .resp_o (alu_resp)
    );

    mul_unit u_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (mul_start),
        .flush_i   (flush_i),
        .op_i      (req_i.mul_op),
        .a_i       (req_i.src_a),
        .b_i       (req_i.src_b),
        .done_o    (mul_done),
        .busy_o    (mul_busy),
        .product_o (mul_product)
    );

    ex_result_stage u_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .alu_valid_i   (alu_valid),
        .alu_resp_i    (alu_resp),
        .alu_word_i    (req_i.word),
        .mul_done_i    (mul_done),
        .mul_product_i (mul_product),
        .mul_word_i    (mul_word_q),
        .mul_busy_i    (mul_busy),
        .resp_valid_o  (resp_valid_o),
        .resp_o        (resp_o),
        .busy_o        (busy_o)
    );

endmodule

`default_nettype wire

/* logic/int_alu.sv */
`include "ex_config.svh"
`timescale 1ns/10ps
`default_nettype none

module int_alu (
    input  ex_pkg::ex_req_t  req_i,
    output ex_pkg::ex_resp_t resp_o
);

    localparam int XLEN = `EX_XLEN;
    localparam int HALF = `EX_XLEN / 2;
    localparam int SHW  = $clog2(`EX_XLEN);

    logic            is_sub;
    logic            is_right;
    logic [XLEN-1:0] b_opnd;
    logic [XLEN-1:0] sum;
    logic            carry;
    logic            overflow;
    logic            less;

    logic [SHW-1:0]  shamt;
    logic [XLEN-1:0] shft_src;
    logic [XLEN-1:0] shft_res;
    logic [XLEN-1:0] sr_mask;
    logic [XLEN-1:0] sr_mask_n;
    logic [XLEN-1:0] srl_res;
    logic [XLEN-1:0] sra_res;
    logic [XLEN-1:0] sll_res;
    logic [XLEN-1:0] alu_out;

    // mirror a word so one right shifter also serves left shifts
    function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] v);
        logic [XLEN-1:0] r;
        for (int i = 0; i < XLEN; i++) begin
            r[i] = v[XLEN-1-i];
        end
        return r;
    endfunction

    // subtract for sub and both compares
    assign is_sub = req_i.alu_op inside {ex_pkg::ALU_SUB, ex_pkg::ALU_SLT, ex_pkg::ALU_SLTU};
    assign b_opnd = req_i.src_b ^ {XLEN{is_sub}};

    assign {carry, sum} = {1'b0, req_i.src_a} + {1'b0, b_opnd} + {{XLEN{1'b0}}, is_sub};

    assign overflow = (req_i.src_a[XLEN-1] == b_opnd[XLEN-1]) &&
                      (sum[XLEN-1] != req_i.src_a[XLEN-1]);

    // unsigned borrow is the missing carry out
    assign less = (req_i.alu_op == ex_pkg::ALU_SLTU) ? ~carry : (sum[XLEN-1] ^ overflow);

    assign is_right = req_i.alu_op inside {ex_pkg::ALU_SRL, ex_pkg::ALU_SRA};

    // word shifts only look at five amount bits
    assign shamt = req_i.word ? {1'b0, req_i.src_b[SHW-2:0]} : req_i.src_b[SHW-1:0];

    assign shft_src  = is_right ? req_i.src_a : bit_rev(req_i.src_a);
    assign shft_res  = shft_src >> shamt;
    assign sr_mask   = {XLEN{1'b1}} >> shamt;
    assign sr_mask_n = ~sr_mask;

    // word form keeps only the bits that came from the low half
    assign srl_res = req_i.word ? (shft_res & {{HALF{1'b0}}, sr_mask[XLEN-1:HALF]})
                                : shft_res;

    always_comb begin
        if (req_i.word) begin
            if (req_i.src_a[HALF-1]) begin
                sra_res = shft_res | {{HALF{1'b1}}, sr_mask_n[XLEN-1:HALF]};
            end else begin
                sra_res = shft_res & {{HALF{1'b0}}, sr_mask[XLEN-1:HALF]};
            end
        end else begin
            sra_res = shft_res | ({XLEN{req_i.src_a[XLEN-1]}} & sr_mask_n);
        end
    end

    // upper half of a word sll is don't care, the result stage extends bit 31
    assign sll_res = bit_rev(shft_res);

    always_comb begin
        case (req_i.alu_op)
            ex_pkg::ALU_ADD,
            ex_pkg::ALU_SUB:   alu_out = sum;
            ex_pkg::ALU_SLT,
            ex_pkg::ALU_SLTU:  alu_out = {{(XLEN-1){1'b0}}, less};
            ex_pkg::ALU_SLL:   alu_out = sll_res;
            ex_pkg::ALU_SRL:   alu_out = srl_res;
            ex_pkg::ALU_SRA:   alu_out = sra_res;
            ex_pkg::ALU_XOR:   alu_out = req_i.src_a ^ req_i.src_b;
            ex_pkg::ALU_OR:    alu_out = req_i.src_a | req_i.src_b;
            ex_pkg::ALU_AND:   alu_out = req_i.src_a & req_i.src_b;
            ex_pkg::ALU_PASSB: alu_out = req_i.src_b;
            default:           alu_out = sum;
        endcase
    end

    always_comb begin
        resp_o.result = alu_out;
        resp_o.zero   = ~(|sum);
        resp_o.less   = less;
    end

endmodule

`default_nettype wire

/* logic/mul_unit.sv */
`include "ex_config.svh"
`timescale 1ns/10ps
`default_nettype none

module mul_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start_i,
    input  logic                flush_i,
    input  ex_pkg::mul_op_e     op_i,
    input  logic [`EX_XLEN-1:0] a_i,
    input  logic [`EX_XLEN-1:0] b_i,
    output logic                done_o,
    output logic                busy_o,
    output logic [`EX_XLEN-1:0] product_o
);

    localparam int XLEN  = `EX_XLEN;
    localparam int CNT_W = $clog2(`EX_MUL_STEPS);

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        FIX  = 2'd2
    } state_e;

    state_e            state_q;
    state_e            state_d;
    logic [CNT_W-1:0]  cnt_q;
    logic              last_step;
    logic              load;

    logic [XLEN-1:0]   mcand_q;
    logic [2*XLEN-1:0] prod_q;
    logic              neg_q;
    ex_pkg::mul_op_e   op_q;

    logic              a_signed;
    logic              b_signed;
    logic              a_neg;
    logic              b_neg;
    logic [XLEN-1:0]   a_mag;
    logic [XLEN-1:0]   b_mag;
    logic [XLEN:0]     step_sum;
    logic [2*XLEN-1:0] prod_fix;

    // mulhsu treats only a as signed, the low product ignores signs
    assign a_signed = op_i inside {ex_pkg::MUL_HSS, ex_pkg::MUL_HSU};
    assign b_signed = (op_i == ex_pkg::MUL_HSS);
    assign a_neg    = a_signed & a_i[XLEN-1];
    assign b_neg    = b_signed & b_i[XLEN-1];
    assign a_mag    = a_neg ? (~a_i + 1'b1) : a_i;
    assign b_mag    = b_neg ? (~b_i + 1'b1) : b_i;

    assign load      = (state_q == IDLE) && start_i;
    assign last_step = (cnt_q == CNT_W'(`EX_MUL_STEPS - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_i) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                if (flush_i) begin
                    state_d = IDLE;
                end else if (last_step) begin
                    state_d = FIX;
                end
            end
            FIX:     state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            done_o  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (load) begin
                cnt_q <= '0;
            end else if (state_q == RUN) begin
                cnt_q <= cnt_q + 1'b1;
            end
            // a flush in the fix cycle still kills the result
            done_o <= (state_q == FIX) && !flush_i;
        end
    end

    // add the multiplicand into the upper half when the low bit is set
    assign step_sum = {1'b0, prod_q[2*XLEN-1:XLEN]} +
                      (prod_q[0] ? {1'b0, mcand_q} : {(XLEN+1){1'b0}});

    assign prod_fix = neg_q ? (~prod_q + 1'b1) : prod_q;

    always_ff @(posedge clk) begin
        if (load) begin
            mcand_q <= a_mag;
            prod_q  <= {{XLEN{1'b0}}, b_mag};
            neg_q   <= a_neg ^ b_neg;
            op_q    <= op_i;
        end else if (state_q == RUN) begin
            prod_q <= {step_sum, prod_q[XLEN-1:1]};
        end
        if (state_q == FIX) begin
            product_o <= (op_q == ex_pkg::MUL_LO) ? prod_fix[XLEN-1:0]
                                                  : prod_fix[2*XLEN-1:XLEN];
        end
    end

    assign busy_o = (state_q != IDLE);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module ex_unit_tb -f vlog.f --Mdir "$BUILD" -o ex_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD/ex_unit_sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    echo "result: PASS"
    exit 0
fi
echo "result: FAIL"
exit 1

/* verif/ex_unit_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module ex_unit_asserts (
    input logic clk,
    input logic rst_n,
    input logic resp_valid_i,
    input logic alu_valid_i,
    input logic mul_start_i,
    input logic mul_done_i,
    input logic flush_i,
    input logic busy_i
);

    int   fail_count;
    logic mul_open_q;

    initial begin
        fail_count = 0;
    end

    // open from multiply start until its done pulse or a flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mul_open_q <= 1'b0;
        end else if (mul_start_i) begin
            mul_open_q <= 1'b1;
        end else if (mul_done_i || flush_i) begin
            mul_open_q <= 1'b0;
        end
    end

    // a response is a single-cycle pulse
    valid_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) resp_valid_i |=> !resp_valid_i
    ) else begin
        $error("resp_valid_o stayed high for two cycles");
        fail_count++;
    end

    // no alu strobe while a multiply is open, its done cycle included
    strobes_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(alu_valid_i && mul_open_q)
    ) else begin
        $error("alu strobe accepted while a multiply was in flight");
        fail_count++;
    end

    busy_low_out_of_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !busy_i
    ) else begin
        $error("busy_o high when reset was released");
        fail_count++;
    end

endmodule

bind ex_unit_top ex_unit_asserts u_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .resp_valid_i (resp_valid_o),
    .alu_valid_i  (alu_valid),
    .mul_start_i  (mul_start),
    .mul_done_i   (mul_done),
    .flush_i      (flush_i),
    .busy_i       (busy_o)
);

`default_nettype wire

/* verif/ex_unit_tb.sv */
`include "ex_config.svh"
`timescale 1ns/10ps
`default_nettype none

module ex_unit_tb;

    localparam int XLEN      = `EX_XLEN;
    localparam int N_ALU     = 60;
    localparam int N_WORD    = 40;
    localparam int N_MUL     = 30;
    localparam int TOTAL_OPS = N_ALU + N_WORD + N_MUL + 4;
    localparam int WAIT_MAX  = `EX_MUL_STEPS + 10;

    logic             clk;
    logic             rst_n;
    logic             req_valid;
    ex_pkg::ex_req_t  req;
    logic             flush;
    logic             resp_valid;
    ex_pkg::ex_resp_t resp;
    logic             busy;

    logic [31:0]      lfsr;
    int               errors;
    int               checks;

    ex_unit_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (req_valid),
        .req_i        (req),
        .flush_i      (flush),
        .resp_valid_o (resp_valid),
        .resp_o       (resp),
        .busy_o       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [XLEN-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[XLEN-2:0], lfsr[0]};
        end
    endtask

    // corner operands show up in about a third of the picks
    task automatic pick_operand(output logic [XLEN-1:0] v);
        logic [XLEN-1:0] sel;
        take_bits(3, sel);
        case (sel[2:0])
            3'd0:    v = {1'b1, {(XLEN-1){1'b0}}};
            3'd1:    v = '1;
            3'd2:    v = '0;
            default: take_bits(XLEN, v);
        endcase
    endtask

    function automatic logic [XLEN-1:0] sext_word(input logic [XLEN-1:0] v);
        return {{(XLEN-32){v[31]}}, v[31:0]};
    endfunction

    function automatic ex_pkg::ex_resp_t alu_model(input ex_pkg::ex_req_t r);
        ex_pkg::ex_resp_t m;
        logic [XLEN-1:0]  sum;
        logic [31:0]      aw;
        logic [5:0]       sh;
        aw = r.src_a[31:0];
        sh = r.word ? {1'b0, r.src_b[4:0]} : r.src_b[5:0];
        if (r.alu_op inside {ex_pkg::ALU_SUB, ex_pkg::ALU_SLT, ex_pkg::ALU_SLTU}) begin
            sum = r.src_a - r.src_b;
        end else begin
            sum = r.src_a + r.src_b;
        end
        m.zero = (sum == '0);
        if (r.alu_op == ex_pkg::ALU_SLTU) begin
            m.less = (r.src_a < r.src_b);
        end else begin
            m.less = ($signed(r.src_a) < $signed(r.src_b));
        end
        case (r.alu_op)
            ex_pkg::ALU_SLT,
            ex_pkg::ALU_SLTU:  m.result = XLEN'(m.less);
            ex_pkg::ALU_SLL:   m.result = r.word ? XLEN'(aw << sh) : r.src_a << sh;
            ex_pkg::ALU_SRL:   m.result = r.word ? XLEN'(aw >> sh) : r.src_a >> sh;
            ex_pkg::ALU_SRA:   m.result = r.word ? XLEN'($signed(aw) >>> sh)
                                                 : $signed(r.src_a) >>> sh;
            ex_pkg::ALU_XOR:   m.result = r.src_a ^ r.src_b;
            ex_pkg::ALU_OR:    m.result = r.src_a | r.src_b;
            ex_pkg::ALU_AND:   m.result = r.src_a & r.src_b;
            ex_pkg::ALU_PASSB: m.result = r.src_b;
            default:           m.result = sum;
        endcase
        if (r.word) begin
            m.result = sext_word(m.result);
        end
        return m;
    endfunction

    // full 128-bit product of the operands extended by their signedness
    function automatic logic [XLEN-1:0] mul_model(input ex_pkg::ex_req_t r);
        logic [2*XLEN-1:0] ea;
        logic [2*XLEN-1:0] eb;
        logic [2*XLEN-1:0] p;
        logic              a_sgn;
        logic              b_sgn;
        a_sgn = (r.mul_op == ex_pkg::MUL_HSS) || (r.mul_op == ex_pkg::MUL_HSU);
        b_sgn = (r.mul_op == ex_pkg::MUL_HSS);
        ea = {{XLEN{a_sgn & r.src_a[XLEN-1]}}, r.src_a};
        eb = {{XLEN{b_sgn & r.src_b[XLEN-1]}}, r.src_b};
        p = ea * eb;
        if (r.mul_op != ex_pkg::MUL_LO) begin
            return p[2*XLEN-1:XLEN];
        end
        return r.word ? sext_word(p[XLEN-1:0]) : p[XLEN-1:0];
    endfunction

    task automatic random_alu(input logic word, output ex_pkg::ex_req_t r);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] v;
        take_bits(XLEN, a);
        take_bits(XLEN, b);
        take_bits(6, v);
        r = '0;
        r.word = word;
        if (word) begin
            case (v[2:0] % 3'd5)
                3'd0:    r.alu_op = ex_pkg::ALU_ADD;
                3'd1:    r.alu_op = ex_pkg::ALU_SUB;
                3'd2:    r.alu_op = ex_pkg::ALU_SLL;
                3'd3:    r.alu_op = ex_pkg::ALU_SRL;
                default: r.alu_op = ex_pkg::ALU_SRA;
            endcase
            // edge shift amounts and negative low words
            if (v[4:3] == 2'd0) begin
                b[4:0] = 5'd0;
            end else if (v[4:3] == 2'd1) begin
                b[4:0] = 5'd31;
            end
            if (v[5]) begin
                a[31] = 1'b1;
            end
        end else begin
            r.alu_op = ex_pkg::alu_op_e'(v[3:0] % 4'd11);
            // equal operands exercise zero and the compare boundary
            if (v[5:4] == 2'd0) begin
                b = a;
            end
        end
        r.src_a = a;
        r.src_b = b;
    endtask

    task automatic random_mul(output ex_pkg::ex_req_t r);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] v;
        take_bits(3, v);
        pick_operand(a);
        pick_operand(b);
        r = '0;
        r.is_mul = 1'b1;
        r.mul_op = ex_pkg::mul_op_e'(v[1:0]);
        r.word   = (v[1:0] == 2'd0) && v[2];
        r.src_a  = a;
        r.src_b  = b;
    endtask

    task automatic send_req(input ex_pkg::ex_req_t r);
        @(negedge clk);
        req       = r;
        req_valid = 1'b1;
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic await_resp(output logic got);
        int n;
        n = 0;
        while (!resp_valid && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        got = resp_valid;
        if (!got) begin
            $display("no response at t=%0t within %0d cycles of the request", $time, WAIT_MAX);
            errors++;
        end
    endtask

    task automatic compare(input string name, input logic [XLEN-1:0] want,
                           input logic [XLEN-1:0] act);
        checks++;
        if (act !== want) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, want, act);
            errors++;
        end
    endtask

    task automatic run_op(input ex_pkg::ex_req_t r, input logic flags);
        ex_pkg::ex_resp_t want;
        logic             got;
        if (r.is_mul) begin
            want.result = mul_model(r);
            want.zero   = 1'b0;
            want.less   = 1'b0;
        end else begin
            want = alu_model(r);
        end
        send_req(r);
        await_resp(got);
        if (got) begin
            compare("resp_o.result", want.result, resp.result);
            if (flags) begin
                compare("resp_o.zero", XLEN'(want.zero), XLEN'(resp.zero));
                if (r.is_mul ||
                    (r.alu_op inside {ex_pkg::ALU_SUB, ex_pkg::ALU_SLT, ex_pkg::ALU_SLTU})) begin
                    compare("resp_o.less", XLEN'(want.less), XLEN'(resp.less));
                end
            end
        end
    endtask

    task automatic end_test(input string name, input int err0, input int chk0);
        $display("test %-10s %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    initial begin
        ex_pkg::ex_req_t r;
        ex_pkg::ex_req_t extra;
        logic [XLEN-1:0] want;
        logic            got;
        int              err0;
        int              chk0;
        lfsr      = 32'he53d69b3;
        errors    = 0;
        checks    = 0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        flush     = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        err0 = errors;
        chk0 = checks;
        for (int i = 0; i < N_ALU; i++) begin
            random_alu(1'b0, r);
            run_op(r, 1'b1);
        end
        end_test("alu", err0, chk0);

        err0 = errors;
        chk0 = checks;
        for (int i = 0; i < N_WORD; i++) begin
            random_alu(1'b1, r);
            run_op(r, 1'b0);
        end
        end_test("alu_word", err0, chk0);

        err0 = errors;
        chk0 = checks;
        for (int i = 0; i < N_MUL; i++) begin
            random_mul(r);
            run_op(r, 1'b1);
        end
        end_test("mul", err0, chk0);

        // second request lands while the multiplier is running
        err0 = errors;
        chk0 = checks;
        random_mul(r);
        random_alu(1'b0, extra);
        want = mul_model(r);
        send_req(r);
        if (!busy) begin
            $display("busy_o low at t=%0t while a multiply was running", $time);
            errors++;
        end
        send_req(extra);
        await_resp(got);
        if (got) begin
            compare("resp_o.result", want, resp.result);
        end
        repeat (4) begin
            @(negedge clk);
            if (resp_valid) begin
                $display("extra response at t=%0t from a request sent while busy", $time);
                errors++;
            end
        end
        end_test("busy_drop", err0, chk0);

        err0 = errors;
        chk0 = checks;
        random_mul(r);
        send_req(r);
        repeat (8) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        if (busy) begin
            $display("busy_o still high at t=%0t after the flush", $time);
            errors++;
        end
        repeat (`EX_MUL_STEPS + 4) begin
            @(negedge clk);
            if (resp_valid) begin
                $display("response at t=%0t from a flushed multiply", $time);
                errors++;
            end
        end
        random_alu(1'b0, r);
        run_op(r, 1'b1);
        end_test("flush", err0, chk0);

        $display("total: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, UUT.u_asserts.fail_count);
        if (errors == 0 && UUT.u_asserts.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        repeat (TOTAL_OPS * WAIT_MAX + 20) @(posedge clk);
        $display("watchdog expired before all tests finished");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/ex_pkg.sv
logic/int_alu.sv
logic/mul_unit.sv
logic/ex_result_stage.sv
logic/ex_unit_top.sv
verif/ex_unit_asserts.sv
verif/ex_unit_tb.sv
